//--- src/mips_pkg.sv
package mips_pkg;

    // data path and opcode widths
    parameter int DATA_W   = 32;
    parameter int OPCODE_W = 6;

    typedef logic [4:0] reg_id_t; // register number

    // loads whose low three bits pick the extension in mem_wb
    parameter logic [OPCODE_W-1:0] OP_LB  = 6'h20;
    parameter logic [OPCODE_W-1:0] OP_LH  = 6'h21;
    parameter logic [OPCODE_W-1:0] OP_LW  = 6'h23;
    parameter logic [OPCODE_W-1:0] OP_LBU = 6'h24;
    parameter logic [OPCODE_W-1:0] OP_LHU = 6'h25;

    // stores whose low two bits pick the byte lanes
    parameter logic [OPCODE_W-1:0] OP_SB  = 6'h28;
    parameter logic [OPCODE_W-1:0] OP_SH  = 6'h29;
    parameter logic [OPCODE_W-1:0] OP_SW  = 6'h2b;

endpackage

//--- src/mem_stage_if.sv
`timescale 1ns/1ns

interface mem_stage_if;

    logic [mips_pkg::OPCODE_W-1:0] opcode;
    logic                          mem_to_reg;
    logic                          mem_write;
    logic [mips_pkg::DATA_W-1:0]   result;     // alu result or address
    logic [mips_pkg::DATA_W-1:0]   store_data;
    logic                          reg_write;
    mips_pkg::reg_id_t             reg_dst_id;

    modport producer (
        output opcode, mem_to_reg, mem_write, result, store_data, reg_write, reg_dst_id
    );

    modport consumer (
        input opcode, mem_to_reg, mem_write, result, store_data, reg_write, reg_dst_id
    );

endinterface

//--- src/ex_mem.sv
`timescale 1ns/1ns

module ex_mem (
    input  logic                          sys_clk,
    input  logic                          rst_n,
    input  logic                          stall,
    input  logic [mips_pkg::OPCODE_W-1:0] ex_opcode,
    input  logic                          ex_mem_to_reg,
    input  logic                          ex_mem_write,
    input  logic [mips_pkg::DATA_W-1:0]   ex_result,
    input  logic [mips_pkg::DATA_W-1:0]   ex_store_data,
    input  logic                          ex_reg_write,
    input  mips_pkg::reg_id_t             ex_reg_dst_id,
    mem_stage_if.producer                 mo
);

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            mo.opcode     <= '0;
            mo.mem_to_reg <= 1'b0;
            mo.mem_write  <= 1'b0;
            mo.result     <= '0;
            mo.store_data <= '0;
            mo.reg_write  <= 1'b0;
            mo.reg_dst_id <= '0;
        end else if (!stall) begin
            mo.opcode     <= ex_opcode;
            mo.mem_to_reg <= ex_mem_to_reg;
            mo.mem_write  <= ex_mem_write;
            mo.result     <= ex_result;
            mo.store_data <= ex_store_data;
            mo.reg_write  <= ex_reg_write;
            mo.reg_dst_id <= ex_reg_dst_id;
        end
        // hold everything on stall
    end

    // the stage never holds a store that also writes a register
    no_store_with_reg_write: assert property (
        @(posedge sys_clk) disable iff (!rst_n)
        !(mo.mem_write && mo.reg_write)
    );

endmodule

//--- src/data_mem.sv
`timescale 1ns/1ns

module data_mem #(
    parameter int MEM_DEPTH = 64 // words
) (
    input  logic                        sys_clk,
    mem_stage_if.consumer               mi,
    output logic [mips_pkg::DATA_W-1:0] mem_read_data
);

    localparam int ADDR_W = $clog2(MEM_DEPTH);

    logic [mips_pkg::DATA_W-1:0] mem [MEM_DEPTH];
    logic [ADDR_W-1:0]           word_addr;
    logic [1:0]                  byte_off;

    assign word_addr = mi.result[ADDR_W+1:2]; // drop byte offset
    assign byte_off  = mi.result[1:0];

    assign mem_read_data = mem[word_addr];

    always_ff @(posedge sys_clk) begin
        if (mi.mem_write) begin
            case (mi.opcode[1:0])
                mips_pkg::OP_SB[1:0]:
                    mem[word_addr][{byte_off, 3'b000} +: 8] <= mi.store_data[7:0];
                mips_pkg::OP_SH[1:0]:
                    mem[word_addr][{byte_off[1], 4'b0000} +: 16] <= mi.store_data[15:0];
                mips_pkg::OP_SW[1:0]:
                    mem[word_addr] <= mi.store_data;
                default: ; // no store width
            endcase
        end
    end

    // store address from ex_mem must fit the array
    store_addr_in_range: assert property (
        @(posedge sys_clk)
        mi.mem_write |-> (mi.result[mips_pkg::DATA_W-1:2] < MEM_DEPTH)
    );

endmodule

//--- src/mem_wb.sv
`timescale 1ns/1ns

module mem_wb (
    input  logic                        sys_clk,
    input  logic                        rst_n,
    input  logic                        stall,
    mem_stage_if.consumer               mi,
    input  logic [mips_pkg::DATA_W-1:0] mem_read_data,
    output logic                        wb_reg_write,
    output mips_pkg::reg_id_t           wb_reg_dst_id,
    output logic [mips_pkg::DATA_W-1:0] wb_reg_wdata,
    output logic                        fwd_mem_reg_write,
    output mips_pkg::reg_id_t           fwd_mem_reg_dst_id,
    output logic [mips_pkg::DATA_W-1:0] fwd_mem_result
);

    logic [mips_pkg::OPCODE_W-1:0] opcode_q;
    logic                          mem_to_reg_q;
    logic [mips_pkg::DATA_W-1:0]   result_q;
    logic                          reg_write_q;
    mips_pkg::reg_id_t             reg_dst_id_q;
    logic [mips_pkg::DATA_W-1:0]   rd_data_q;

    logic [7:0]                    byte_sel;
    logic [15:0]                   half_sel;
    logic [mips_pkg::DATA_W-1:0]   load_data;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            opcode_q     <= '0;
            mem_to_reg_q <= 1'b0;
            result_q     <= '0;
            reg_write_q  <= 1'b0;
            reg_dst_id_q <= '0;
            rd_data_q    <= '0;
        end else if (!stall) begin
            opcode_q     <= mi.opcode;
            mem_to_reg_q <= mi.mem_to_reg;
            result_q     <= mi.result;
            reg_write_q  <= mi.reg_write;
            reg_dst_id_q <= mi.reg_dst_id;
            rd_data_q    <= mem_read_data;
        end
    end

    // lane select by registered address
    assign byte_sel = rd_data_q[{result_q[1:0], 3'b000} +: 8];
    assign half_sel = rd_data_q[{result_q[1], 4'b0000} +: 16];

    always_comb begin
        case (opcode_q[2:0])
            mips_pkg::OP_LB[2:0]:  load_data = {{24{byte_sel[7]}}, byte_sel};
            mips_pkg::OP_LH[2:0]:  load_data = {{16{half_sel[15]}}, half_sel};
            mips_pkg::OP_LW[2:0]:  load_data = rd_data_q;
            mips_pkg::OP_LBU[2:0]: load_data = {24'b0, byte_sel};
            mips_pkg::OP_LHU[2:0]: load_data = {16'b0, half_sel};
            default:               load_data = rd_data_q; // full word
        endcase
    end

    assign wb_reg_write  = reg_write_q;
    assign wb_reg_dst_id = reg_dst_id_q;
    assign wb_reg_wdata  = mem_to_reg_q ? load_data : result_q;

    // same values go back for forwarding
    assign fwd_mem_reg_write  = reg_write_q;
    assign fwd_mem_reg_dst_id = reg_dst_id_q;
    assign fwd_mem_result     = wb_reg_wdata;

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                        sys_clk,
    input  logic                        rst_n,
    input  logic                        wr_en,
    input  mips_pkg::reg_id_t           wr_id,
    input  logic [mips_pkg::DATA_W-1:0] wr_data,
    input  mips_pkg::reg_id_t           rs_id,
    input  mips_pkg::reg_id_t           rt_id,
    output logic [mips_pkg::DATA_W-1:0] rs_data,
    output logic [mips_pkg::DATA_W-1:0] rt_data
);

    logic [mips_pkg::DATA_W-1:0] regs [32];

    // one read port with bypass of the write in flight
    function automatic logic [mips_pkg::DATA_W-1:0] read_port(input mips_pkg::reg_id_t id);
        if (id == '0)
            return '0;
        else if (wr_en && (id == wr_id))
            return wr_data;
        else
            return regs[id];
    endfunction

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_id != '0)) begin
            regs[wr_id] <= wr_data;
        end
    end

    always_comb begin
        rs_data = read_port(rs_id);
        rt_data = read_port(rt_id);
    end

endmodule

//--- src/mips_mem_wb_stages.sv
`timescale 1ns/1ns

module mips_mem_wb_stages #(
    parameter int MEM_DEPTH = 64
) (
    input  logic                          sys_clk,
    input  logic                          rst_n,
    input  logic                          stall,
    input  logic [mips_pkg::OPCODE_W-1:0] ex_opcode,
    input  logic                          ex_mem_to_reg,
    input  logic                          ex_mem_write,
    input  logic [mips_pkg::DATA_W-1:0]   ex_result,
    input  logic [mips_pkg::DATA_W-1:0]   ex_store_data,
    input  logic                          ex_reg_write,
    input  mips_pkg::reg_id_t             ex_reg_dst_id,
    input  mips_pkg::reg_id_t             rs_id,
    input  mips_pkg::reg_id_t             rt_id,
    output logic [mips_pkg::DATA_W-1:0]   rs_data,
    output logic [mips_pkg::DATA_W-1:0]   rt_data,
    output logic                          wb_reg_write,
    output mips_pkg::reg_id_t             wb_reg_dst_id,
    output logic [mips_pkg::DATA_W-1:0]   wb_reg_wdata,
    output logic                          fwd_ex_reg_write,
    output mips_pkg::reg_id_t             fwd_ex_reg_dst_id,
    output logic [mips_pkg::DATA_W-1:0]   fwd_ex_result,
    output logic                          fwd_mem_reg_write,
    output mips_pkg::reg_id_t             fwd_mem_reg_dst_id,
    output logic [mips_pkg::DATA_W-1:0]   fwd_mem_result
);

    mem_stage_if ms ();

    logic [mips_pkg::DATA_W-1:0] mem_read_data;

    ex_mem i_ex_mem (
        .sys_clk       (sys_clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .ex_opcode     (ex_opcode),
        .ex_mem_to_reg (ex_mem_to_reg),
        .ex_mem_write  (ex_mem_write),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data),
        .ex_reg_write  (ex_reg_write),
        .ex_reg_dst_id (ex_reg_dst_id),
        .mo            (ms.producer)
    );

    // ex/mem forwarding straight off the stage register
    assign fwd_ex_reg_write  = ms.reg_write;
    assign fwd_ex_reg_dst_id = ms.reg_dst_id;
    assign fwd_ex_result     = ms.result;

    data_mem #(.MEM_DEPTH(MEM_DEPTH)) i_data_mem (
        .sys_clk       (sys_clk),
        .mi            (ms.consumer),
        .mem_read_data (mem_read_data)
    );

    mem_wb i_mem_wb (
        .sys_clk            (sys_clk),
        .rst_n              (rst_n),
        .stall              (stall),
        .mi                 (ms.consumer),
        .mem_read_data      (mem_read_data),
        .wb_reg_write       (wb_reg_write),
        .wb_reg_dst_id      (wb_reg_dst_id),
        .wb_reg_wdata       (wb_reg_wdata),
        .fwd_mem_reg_write  (fwd_mem_reg_write),
        .fwd_mem_reg_dst_id (fwd_mem_reg_dst_id),
        .fwd_mem_result     (fwd_mem_result)
    );

    reg_file i_reg_file (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .wr_en   (wb_reg_write),
        .wr_id   (wb_reg_dst_id),
        .wr_data (wb_reg_wdata),
        .rs_id   (rs_id),
        .rt_id   (rt_id),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

endmodule

//--- tests/load_store_table.svh
// columns are opcode, mem_to_reg, mem_write, reg_write, address or result, store data,
// destination, expected write-back data (non-load rows), random store data flag
localparam int N_ROWS = 25;

row_t stim_rows [N_ROWS] = '{
    '{mips_pkg::OP_SW,  1'b0, 1'b1, 1'b0, 32'h10, 32'h8899aabb, 5'd0,  32'h10, 1'b0},
    '{mips_pkg::OP_SW,  1'b0, 1'b1, 1'b0, 32'h14, 32'h0,        5'd0,  32'h14, 1'b1},
    '{mips_pkg::OP_SH,  1'b0, 1'b1, 1'b0, 32'h20, 32'h1234f00d, 5'd0,  32'h20, 1'b0},
    '{mips_pkg::OP_SH,  1'b0, 1'b1, 1'b0, 32'h22, 32'h00007e11, 5'd0,  32'h22, 1'b0},
    '{mips_pkg::OP_SB,  1'b0, 1'b1, 1'b0, 32'h24, 32'h00000080, 5'd0,  32'h24, 1'b0},
    '{mips_pkg::OP_SB,  1'b0, 1'b1, 1'b0, 32'h25, 32'h0000007f, 5'd0,  32'h25, 1'b0},
    '{mips_pkg::OP_SB,  1'b0, 1'b1, 1'b0, 32'h26, 32'h0,        5'd0,  32'h26, 1'b1},
    '{mips_pkg::OP_SB,  1'b0, 1'b1, 1'b0, 32'h27, 32'h0,        5'd0,  32'h27, 1'b1},
    '{mips_pkg::OP_LW,  1'b1, 1'b0, 1'b1, 32'h10, 32'h0,        5'd1,  32'h0,  1'b0},
    '{mips_pkg::OP_LW,  1'b1, 1'b0, 1'b1, 32'h14, 32'h0,        5'd2,  32'h0,  1'b0},
    '{mips_pkg::OP_LH,  1'b1, 1'b0, 1'b1, 32'h20, 32'h0,        5'd3,  32'h0,  1'b0},
    '{mips_pkg::OP_LH,  1'b1, 1'b0, 1'b1, 32'h22, 32'h0,        5'd4,  32'h0,  1'b0},
    '{mips_pkg::OP_LHU, 1'b1, 1'b0, 1'b1, 32'h20, 32'h0,        5'd5,  32'h0,  1'b0},
    '{mips_pkg::OP_LHU, 1'b1, 1'b0, 1'b1, 32'h22, 32'h0,        5'd6,  32'h0,  1'b0},
    '{mips_pkg::OP_LB,  1'b1, 1'b0, 1'b1, 32'h24, 32'h0,        5'd7,  32'h0,  1'b0},
    '{mips_pkg::OP_LB,  1'b1, 1'b0, 1'b1, 32'h25, 32'h0,        5'd8,  32'h0,  1'b0},
    '{mips_pkg::OP_LB,  1'b1, 1'b0, 1'b1, 32'h26, 32'h0,        5'd9,  32'h0,  1'b0},
    '{mips_pkg::OP_LB,  1'b1, 1'b0, 1'b1, 32'h27, 32'h0,        5'd10, 32'h0,  1'b0},
    '{mips_pkg::OP_LBU, 1'b1, 1'b0, 1'b1, 32'h24, 32'h0,        5'd11, 32'h0,  1'b0},
    '{mips_pkg::OP_LBU, 1'b1, 1'b0, 1'b1, 32'h25, 32'h0,        5'd12, 32'h0,  1'b0},
    '{mips_pkg::OP_LBU, 1'b1, 1'b0, 1'b1, 32'h26, 32'h0,        5'd13, 32'h0,  1'b0},
    '{mips_pkg::OP_LBU, 1'b1, 1'b0, 1'b1, 32'h27, 32'h0,        5'd14, 32'h0,  1'b0},
    '{6'h00, 1'b0, 1'b0, 1'b1, 32'hdeadbeef, 32'h0, 5'd15, 32'hdeadbeef, 1'b0},
    '{6'h00, 1'b0, 1'b0, 1'b1, 32'h12345678, 32'h0, 5'd0,  32'h12345678, 1'b0},
    '{6'h00, 1'b0, 1'b0, 1'b1, 32'h0badcafe, 32'h0, 5'd15, 32'h0badcafe, 1'b0}
};

//--- tests/tb_mips_mem_wb_stages.sv
`timescale 1ns/1ns

module tb_mips_mem_wb_stages;

    typedef struct packed {
        logic [5:0]  op;
        logic        m2r;
        logic        mw;
        logic        rw;
        logic [31:0] addr;
        logic [31:0] sdata;
        logic [4:0]  dst;
        logic [31:0] exp_val;
        logic        rnd;
    } row_t;

    typedef struct packed {
        logic        rw;
        logic [4:0]  dst;
        logic [31:0] result;
        logic [31:0] wdata;
    } exp_t;

    `include "load_store_table.svh"

    localparam int STALL_ROW = 12;
    localparam int MAX_CYCLES = N_ROWS + 20;

    logic sys_clk = 1'b0;
    logic rst_n, stall, ex_mem_to_reg, ex_mem_write, ex_reg_write;
    logic [5:0] ex_opcode;
    logic [31:0] ex_result, ex_store_data;
    logic [4:0] ex_reg_dst_id, rs_id, rt_id;
    logic [31:0] rs_data, rt_data, wb_reg_wdata, fwd_ex_result, fwd_mem_result;
    logic wb_reg_write, fwd_ex_reg_write, fwd_mem_reg_write;
    logic [4:0] wb_reg_dst_id, fwd_ex_reg_dst_id, fwd_mem_reg_dst_id;

    logic [7:0] mem_model [256]; // byte view of data memory
    logic [31:0] reg_model [32];
    exp_t cur_exp, ex_exp, wb_exp;
    int errors = 0;
    int cycles = 0;

    always #2 sys_clk = ~sys_clk;

    mips_mem_wb_stages #(.MEM_DEPTH(64)) i_dut (.*);

    always @(posedge sys_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    // byte, halfword or word from the model extended by opcode
    function automatic logic [31:0] load_expect(input logic [5:0] op, input logic [31:0] addr);
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] w;
        b = mem_model[addr[7:0]];
        h = {mem_model[{addr[7:1], 1'b1}], mem_model[{addr[7:1], 1'b0}]};
        w = {mem_model[{addr[7:2], 2'd3}], mem_model[{addr[7:2], 2'd2}],
             mem_model[{addr[7:2], 2'd1}], mem_model[{addr[7:2], 2'd0}]};
        case (op)
            mips_pkg::OP_LB:  return {{24{b[7]}}, b};
            mips_pkg::OP_LH:  return {{16{h[15]}}, h};
            mips_pkg::OP_LBU: return {24'b0, b};
            mips_pkg::OP_LHU: return {16'b0, h};
            default:          return w;
        endcase
    endfunction

    function automatic logic [31:0] read_expect(input logic [4:0] id);
        if (id == 5'd0)
            return 32'h0;
        else if (wb_exp.rw && wb_exp.dst == id)
            return wb_exp.wdata; // written this cycle
        else
            return reg_model[id];
    endfunction

    task automatic drive_row(input row_t r);
        logic [31:0] d;
        d = r.rnd ? $urandom : r.sdata;
        if (r.mw) begin
            case (r.op)
                mips_pkg::OP_SB: mem_model[r.addr[7:0]] = d[7:0];
                mips_pkg::OP_SH: begin
                    mem_model[{r.addr[7:1], 1'b0}] = d[7:0];
                    mem_model[{r.addr[7:1], 1'b1}] = d[15:8];
                end
                default: begin
                    for (int k = 0; k < 4; k++)
                        mem_model[{r.addr[7:2], 2'b00} + 8'(k)] = d[8*k +: 8];
                end
            endcase
        end
        ex_opcode     <= r.op;
        ex_mem_to_reg <= r.m2r;
        ex_mem_write  <= r.mw;
        ex_reg_write  <= r.rw;
        ex_result     <= r.addr;
        ex_store_data <= d;
        ex_reg_dst_id <= r.dst;
        cur_exp = '{r.rw, r.dst, r.addr, r.m2r ? load_expect(r.op, r.addr) : r.exp_val};
    endtask

    initial begin
        int row;
        int drain;
        int stall_left;
        logic [4:0] probe;
        void'($urandom(32'hd11c));
        {stall, ex_mem_to_reg, ex_mem_write, ex_reg_write, ex_opcode} = '0;
        {ex_result, ex_store_data, ex_reg_dst_id, rs_id, rt_id} = '0;
        rst_n = 1'b0;
        for (int k = 0; k < 32; k++)
            reg_model[k] = 32'h0;
        cur_exp = '0;
        ex_exp = '0;
        wb_exp = '0;
        row = 0;
        drain = 0;
        stall_left = 0;
        repeat (2) @(posedge sys_clk);
        rst_n <= 1'b1;
        while (row < N_ROWS || drain < 3) begin
            @(posedge sys_clk);
            if (wb_exp.rw && wb_exp.dst != 5'd0)
                reg_model[wb_exp.dst] = wb_exp.wdata;
            if (wb_exp.rw)
                probe = wb_exp.dst; // register written at this edge
            else
                probe = 5'(cycles);
            if (!stall) begin
                wb_exp = ex_exp;
                ex_exp = cur_exp;
            end
            if (row == STALL_ROW && stall_left == 0 && !stall) begin
                stall <= 1'b1;
                stall_left = 3;
            end else if (stall_left > 1) begin
                stall_left--;
            end else begin
                if (stall_left == 1) begin
                    stall_left = -1; // never stall again
                    stall <= 1'b0;
                end
                if (row < N_ROWS) begin
                    drive_row(stim_rows[row]);
                    row++;
                end else begin
                    drive_row('0);
                    drain++;
                end
            end
            rs_id <= wb_exp.dst;
            rt_id <= probe;
            @(negedge sys_clk);
            check_value(32'(fwd_ex_reg_write), 32'(ex_exp.rw), "fwd_ex_reg_write");
            check_value(32'(fwd_ex_reg_dst_id), 32'(ex_exp.dst), "fwd_ex_reg_dst_id");
            check_value(fwd_ex_result, ex_exp.result, "fwd_ex_result");
            check_value(32'(wb_reg_write), 32'(wb_exp.rw), "wb_reg_write");
            check_value(32'(wb_reg_dst_id), 32'(wb_exp.dst), "wb_reg_dst_id");
            check_value(wb_reg_wdata, wb_exp.wdata, "wb_reg_wdata");
            check_value(32'(fwd_mem_reg_write), 32'(wb_exp.rw), "fwd_mem_reg_write");
            check_value(32'(fwd_mem_reg_dst_id), 32'(wb_exp.dst), "fwd_mem_reg_dst_id");
            check_value(fwd_mem_result, wb_exp.wdata, "fwd_mem_result");
            check_value(rs_data, read_expect(rs_id), "rs_data");
            check_value(rt_data, read_expect(rt_id), "rt_data");
        end
        $display("run complete, %0d errors in %0d cycles", errors, cycles);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+tests
src/mips_pkg.sv
src/mem_stage_if.sv
src/ex_mem.sv
src/data_mem.sv
src/mem_wb.sv
src/reg_file.sv
src/mips_mem_wb_stages.sv
tests/tb_mips_mem_wb_stages.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips_mem_wb_stages
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TEST PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
